// ==== include/alu_cluster_config.svh ====
// SIMD ALU cluster configuration
// Default lane count and APB address width for the top level
`ifndef ALU_CLUSTER_CONFIG_SVH
`define ALU_CLUSTER_CONFIG_SVH

// Number of ALU lanes, legal range 1 to 16
`define ALU_CLUSTER_LANES 4

// APB address width in bits, at least 8 to cover the map
`define ALU_CLUSTER_ADDR_W 8

`endif

// ==== source/alu_cluster_pkg.sv ====
// SIMD ALU cluster shared definitions
// Micro-operation codes, the data word, the command word views and the APB map
`default_nettype none

package alu_cluster_pkg;

    // ========================================
    // Data and micro-operations
    // ========================================

    localparam int unsigned DATA_W = 32;

    typedef logic [DATA_W-1:0] data_word_t;

    // Jumps and branches occupy the lowest codes so one compare flags them
    typedef enum logic [3:0] {
        JAL  = 4'd0,
        BEQ  = 4'd1,
        BNE  = 4'd2,
        BLT  = 4'd3,
        BLTU = 4'd4,
        BGE  = 4'd5,
        BGEU = 4'd6,
        ADD  = 4'd7,
        AND  = 4'd8,
        OR   = 4'd9,
        XOR  = 4'd10,
        SLT  = 4'd11,
        SLTU = 4'd12,
        SLL  = 4'd13,
        SRL  = 4'd14,
        SRA  = 4'd15
    } alu_uop_t;

    // Highest code that still counts as a jump or branch
    localparam alu_uop_t BRANCH_LAST = BGEU;

    // ========================================
    // Command word
    // ========================================

    // Operand B taken from each lane's own register
    typedef struct packed {
        logic [25:0] reserved;
        logic        imm_sel;
        logic        cjump;
        alu_uop_t    uop;
    } cmd_reg_view_t;

    // Operand B is the immediate, broadcast to all lanes
    typedef struct packed {
        logic [13:0]        reserved;
        logic signed [11:0] imm;
        logic               imm_sel;
        logic               cjump;
        alu_uop_t           uop;
    } cmd_imm_view_t;

    // Bit 5 picks which view is meaningful, low six bits are common
    typedef union packed {
        cmd_reg_view_t reg_view;
        cmd_imm_view_t imm_view;
    } cmd_word_t;

    // ========================================
    // APB address map (byte offsets)
    // ========================================

    localparam int unsigned ADDR_OPA_BASE = 32'h00;
    localparam int unsigned ADDR_OPB_BASE = 32'h40;
    localparam int unsigned ADDR_CMD      = 32'h80;
    localparam int unsigned ADDR_STATUS   = 32'h84;
    localparam int unsigned ADDR_RES_BASE = 32'hC0;

    // Each per-lane window holds up to sixteen words
    localparam int unsigned LANE_WINDOW   = 32'h40;

    // STATUS fields
    localparam int unsigned STATUS_MASK_LSB  = 0;
    localparam int unsigned STATUS_COUNT_LSB = 16;
    localparam int unsigned STATUS_COUNT_W   = 8;

endpackage : alu_cluster_pkg

`default_nettype wire

// ==== source/arithmetic_logic_unit.sv ====
// RV32I ALU lane
// Purely combinational, computes one result and a branch flag per operation
`default_nettype none

module arithmetic_logic_unit (
    input  alu_cluster_pkg::data_word_t operand_a_i,
    input  alu_cluster_pkg::data_word_t operand_b_i,
    input  alu_cluster_pkg::alu_uop_t   operation_i,
    input  logic                        data_valid_i,
    // Compressed jump links to A plus 2 instead of A plus 4
    input  logic                        is_cjump_i,
    output alu_cluster_pkg::data_word_t result_o,
    output logic                        data_valid_o,
    output logic                        is_branch_o
);

    // ========================================
    // Adder and comparators
    // ========================================

    alu_cluster_pkg::data_word_t sum;
    alu_cluster_pkg::data_word_t link_addr;
    logic                        lt_signed;
    logic                        lt_unsigned;
    logic                        equal;

    assign sum = operand_a_i + operand_b_i;

    // Return address for JAL, B plays no part here
    assign link_addr = is_cjump_i ? (operand_a_i + 32'd2) : (operand_a_i + 32'd4);

    assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
    assign lt_unsigned = operand_a_i < operand_b_i;
    assign equal       = (operand_a_i == operand_b_i);

    // ========================================
    // Shifter and logic
    // ========================================

    logic [4:0]                  shamt;
    alu_cluster_pkg::data_word_t sll_res;
    alu_cluster_pkg::data_word_t srl_res;
    alu_cluster_pkg::data_word_t sra_res;

    // Only the low five bits of B count, as in RV32I
    assign shamt   = operand_b_i[4:0];
    assign sll_res = operand_a_i << shamt;
    assign srl_res = operand_a_i >> shamt;
    assign sra_res = $signed(operand_a_i) >>> shamt;

    // ========================================
    // Result select
    // ========================================

    always_comb begin
        case (operation_i)
            alu_cluster_pkg::JAL:  result_o = link_addr;
            // Branch outcomes come back as 0 or 1
            alu_cluster_pkg::BEQ:  result_o = 32'(equal);
            alu_cluster_pkg::BNE:  result_o = 32'(!equal);
            alu_cluster_pkg::BLT:  result_o = 32'(lt_signed);
            alu_cluster_pkg::BLTU: result_o = 32'(lt_unsigned);
            alu_cluster_pkg::BGE:  result_o = 32'(!lt_signed);
            alu_cluster_pkg::BGEU: result_o = 32'(!lt_unsigned);
            alu_cluster_pkg::ADD:  result_o = sum;
            alu_cluster_pkg::AND:  result_o = operand_a_i & operand_b_i;
            alu_cluster_pkg::OR:   result_o = operand_a_i | operand_b_i;
            alu_cluster_pkg::XOR:  result_o = operand_a_i ^ operand_b_i;
            alu_cluster_pkg::SLT:  result_o = 32'(lt_signed);
            alu_cluster_pkg::SLTU: result_o = 32'(lt_unsigned);
            alu_cluster_pkg::SLL:  result_o = sll_res;
            alu_cluster_pkg::SRL:  result_o = srl_res;
            alu_cluster_pkg::SRA:  result_o = sra_res;
            default:               result_o = '0;
        endcase
    end

    assign data_valid_o = data_valid_i;

    // Jumps and branches sit at the bottom of the code space
    assign is_branch_o = (operation_i <= alu_cluster_pkg::BRANCH_LAST) & data_valid_i;

endmodule : arithmetic_logic_unit

`default_nettype wire

// ==== source/operand_bank.sv ====
// Operand bank and APB slave of the SIMD ALU cluster
// Holds per-lane operands and the command, issues work, muxes read data
`default_nettype none

module operand_bank #(
    parameter int unsigned NUM_LANES = 4,
    parameter int unsigned ADDR_W    = 8
) (
    input  logic                                        clk_i,
    input  logic                                        rst_n_i,
    input  logic                                        psel_i,
    input  logic                                        penable_i,
    input  logic                                        pwrite_i,
    input  logic [ADDR_W-1:0]                           paddr_i,
    input  alu_cluster_pkg::data_word_t                 pwdata_i,
    output alu_cluster_pkg::data_word_t                 prdata_o,
    output logic                                        pready_o,
    output logic                                        pslverr_o,
    input  logic [NUM_LANES*alu_cluster_pkg::DATA_W-1:0] res_flat_i,
    input  logic [NUM_LANES-1:0]                        taken_mask_i,
    input  logic [alu_cluster_pkg::STATUS_COUNT_W-1:0]  issue_count_i,
    output logic [NUM_LANES*alu_cluster_pkg::DATA_W-1:0] lane_opa_o,
    output logic [NUM_LANES*alu_cluster_pkg::DATA_W-1:0] lane_opb_o,
    output alu_cluster_pkg::alu_uop_t                   lane_uop_o,
    output logic                                        lane_cjump_o,
    output logic                                        issue_o
);

    localparam int unsigned DW = alu_cluster_pkg::DATA_W;

    // True when the address falls inside a sixteen-word lane window
    function automatic logic in_window(input logic [ADDR_W-1:0] addr, input int unsigned base);
        return (addr >= base) && (addr < base + alu_cluster_pkg::LANE_WINDOW);
    endfunction

    // ========================================
    // Address decode
    // ========================================

    logic              hit_opa, hit_opb, hit_cmd, hit_status, hit_res;
    logic [ADDR_W-1:0] lane_off;
    logic [3:0]        word_idx;
    logic              addr_err;

    assign hit_opa    = in_window(paddr_i, alu_cluster_pkg::ADDR_OPA_BASE);
    assign hit_opb    = in_window(paddr_i, alu_cluster_pkg::ADDR_OPB_BASE);
    assign hit_res    = in_window(paddr_i, alu_cluster_pkg::ADDR_RES_BASE);
    assign hit_cmd    = (paddr_i == alu_cluster_pkg::ADDR_CMD);
    assign hit_status = (paddr_i == alu_cluster_pkg::ADDR_STATUS);

    // Byte offset within whichever lane window was hit
    always_comb begin
        lane_off = paddr_i - ADDR_W'(alu_cluster_pkg::ADDR_OPA_BASE);
        if (hit_opb) lane_off = paddr_i - ADDR_W'(alu_cluster_pkg::ADDR_OPB_BASE);
        if (hit_res) lane_off = paddr_i - ADDR_W'(alu_cluster_pkg::ADDR_RES_BASE);
    end
    assign word_idx = lane_off[5:2];

    // Misaligned, unmapped, missing lane, or a write to a read-only word
    assign addr_err = (paddr_i[1:0] != 2'b00)
                    | !(hit_opa | hit_opb | hit_res | hit_cmd | hit_status)
                    | ((hit_opa | hit_opb | hit_res) & (32'(word_idx) >= NUM_LANES))
                    | (pwrite_i & (hit_status | hit_res));

    logic wr_ok;
    assign wr_ok     = psel_i & penable_i & pwrite_i & !addr_err;
    assign pslverr_o = psel_i & penable_i & addr_err;
    assign pready_o  = 1'b1;

    // ========================================
    // Operand and command registers
    // ========================================

    alu_cluster_pkg::data_word_t opa_q [NUM_LANES];
    alu_cluster_pkg::data_word_t opb_q [NUM_LANES];
    alu_cluster_pkg::cmd_word_t  cmd_q;
    logic                        issue_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                opa_q[l] <= '0;
                opb_q[l] <= '0;
            end
            cmd_q   <= '0;
            issue_q <= 1'b0;
        end else begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (wr_ok && hit_opa && (word_idx == 4'(l))) opa_q[l] <= pwdata_i;
                if (wr_ok && hit_opb && (word_idx == 4'(l))) opb_q[l] <= pwdata_i;
            end
            if (wr_ok && hit_cmd) cmd_q <= alu_cluster_pkg::cmd_word_t'(pwdata_i);
            // One-cycle pulse following each accepted CMD write
            issue_q <= wr_ok & hit_cmd;
        end
    end

    // ========================================
    // Lane drive
    // ========================================

    alu_cluster_pkg::data_word_t imm_ext;

    // Sign-extend the 12-bit immediate of the immediate view
    assign imm_ext = {{20{cmd_q.imm_view.imm[11]}}, cmd_q.imm_view.imm};

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            lane_opa_o[l*DW +: DW] = opa_q[l];
            lane_opb_o[l*DW +: DW] = cmd_q.reg_view.imm_sel ? imm_ext : opb_q[l];
        end
    end

    assign lane_uop_o   = cmd_q.reg_view.uop;
    assign lane_cjump_o = cmd_q.reg_view.cjump;
    assign issue_o      = issue_q;

    // ========================================
    // Read mux
    // ========================================

    alu_cluster_pkg::data_word_t status_word;

    always_comb begin
        status_word = '0;
        status_word[alu_cluster_pkg::STATUS_MASK_LSB +: NUM_LANES] = taken_mask_i;
        status_word[alu_cluster_pkg::STATUS_COUNT_LSB +: alu_cluster_pkg::STATUS_COUNT_W] =
            issue_count_i;
    end

    always_comb begin
        prdata_o = '0;
        if (psel_i && !pwrite_i && !addr_err) begin
            if (hit_cmd) prdata_o = cmd_q;
            if (hit_status) prdata_o = status_word;
            for (int l = 0; l < NUM_LANES; l++) begin
                if (word_idx == 4'(l)) begin
                    if (hit_opa) prdata_o = opa_q[l];
                    if (hit_opb) prdata_o = opb_q[l];
                    if (hit_res) prdata_o = res_flat_i[l*DW +: DW];
                end
            end
        end
    end

endmodule : operand_bank

`default_nettype wire

// ==== source/result_collector.sv ====
// Result collector of the SIMD ALU cluster
// Latches lane results, builds the taken mask and counts issues
`default_nettype none

module result_collector #(
    parameter int unsigned NUM_LANES = 4
) (
    input  logic                                         clk_i,
    input  logic                                         rst_n_i,
    input  logic [NUM_LANES*alu_cluster_pkg::DATA_W-1:0] lane_result_i,
    input  logic [NUM_LANES-1:0]                         lane_valid_i,
    input  logic [NUM_LANES-1:0]                         lane_branch_i,
    output logic [NUM_LANES*alu_cluster_pkg::DATA_W-1:0] res_flat_o,
    output logic [NUM_LANES-1:0]                         taken_mask_o,
    output logic [alu_cluster_pkg::STATUS_COUNT_W-1:0]   issue_count_o
);

    localparam int unsigned DW = alu_cluster_pkg::DATA_W;

    // ========================================
    // Capture registers
    // ========================================

    logic [NUM_LANES*DW-1:0]                    res_q;
    logic [NUM_LANES-1:0]                       taken_q;
    logic [alu_cluster_pkg::STATUS_COUNT_W-1:0] count_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            res_q   <= '0;
            taken_q <= '0;
            count_q <= '0;
        end else begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (lane_valid_i[l]) begin
                    res_q[l*DW +: DW] <= lane_result_i[l*DW +: DW];
                    // A zero branch result means not taken, non-branches never set it
                    taken_q[l] <= lane_branch_i[l] & (|lane_result_i[l*DW +: DW]);
                end
            end
            // Lanes share one issue pulse, so any valid lane marks an issue
            if (|lane_valid_i) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    assign res_flat_o    = res_q;
    assign taken_mask_o  = taken_q;
    assign issue_count_o = count_q;

endmodule : result_collector

`default_nettype wire

// ==== source/alu_cluster.sv ====
// SIMD ALU cluster top level
// APB operand bank feeding a row of ALU lanes, drained by the result collector
`default_nettype none

`include "alu_cluster_config.svh"

module alu_cluster #(
    parameter int unsigned NUM_LANES = `ALU_CLUSTER_LANES,
    parameter int unsigned ADDR_W    = `ALU_CLUSTER_ADDR_W
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  logic [ADDR_W-1:0]           paddr_i,
    input  alu_cluster_pkg::data_word_t pwdata_i,
    output alu_cluster_pkg::data_word_t prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o
);

    localparam int unsigned DW = alu_cluster_pkg::DATA_W;

    // Bank to lanes
    logic [NUM_LANES*DW-1:0]   lane_opa;
    logic [NUM_LANES*DW-1:0]   lane_opb;
    alu_cluster_pkg::alu_uop_t lane_uop;
    logic                      lane_cjump;
    logic                      issue;

    // Lanes to collector
    logic [NUM_LANES*DW-1:0] lane_result;
    logic [NUM_LANES-1:0]    lane_valid;
    logic [NUM_LANES-1:0]    lane_branch;

    // Collector back to bank for reads
    logic [NUM_LANES*DW-1:0]                    res_flat;
    logic [NUM_LANES-1:0]                       taken_mask;
    logic [alu_cluster_pkg::STATUS_COUNT_W-1:0] issue_count;

    operand_bank #(
        .NUM_LANES (NUM_LANES),
        .ADDR_W    (ADDR_W)
    ) i_operand_bank (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .paddr_i       (paddr_i),
        .pwdata_i      (pwdata_i),
        .prdata_o      (prdata_o),
        .pready_o      (pready_o),
        .pslverr_o     (pslverr_o),
        .res_flat_i    (res_flat),
        .taken_mask_i  (taken_mask),
        .issue_count_i (issue_count),
        .lane_opa_o    (lane_opa),
        .lane_opb_o    (lane_opb),
        .lane_uop_o    (lane_uop),
        .lane_cjump_o  (lane_cjump),
        .issue_o       (issue)
    );

    // All lanes run the same operation on their own operand pair
    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        arithmetic_logic_unit i_lane (
            .operand_a_i  (lane_opa[l*DW +: DW]),
            .operand_b_i  (lane_opb[l*DW +: DW]),
            .operation_i  (lane_uop),
            .data_valid_i (issue),
            .is_cjump_i   (lane_cjump),
            .result_o     (lane_result[l*DW +: DW]),
            .data_valid_o (lane_valid[l]),
            .is_branch_o  (lane_branch[l])
        );
    end

    result_collector #(
        .NUM_LANES (NUM_LANES)
    ) i_result_collector (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .lane_result_i (lane_result),
        .lane_valid_i  (lane_valid),
        .lane_branch_i (lane_branch),
        .res_flat_o    (res_flat),
        .taken_mask_o  (taken_mask),
        .issue_count_o (issue_count)
    );

endmodule : alu_cluster

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
// Clock and reset source for the ALU cluster testbench
// Free-running clock with a synchronous active-low reset held for a few cycles
`default_nettype none

module tb_clock_gen #(
    parameter int unsigned PERIOD_NS    = 8,
    parameter int unsigned RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Release on a falling edge so the DUT sees a clean rising edge afterwards
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule : tb_clock_gen

`default_nettype wire

// ==== testbench/tb_alu_cluster.sv ====
// Testbench for the SIMD ALU cluster
// Directed APB tests compared against a behavioral ALU model
`default_nettype none

module tb_alu_cluster;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned NUM_LANES    = 4;
    localparam int unsigned ADDR_W       = 8;
    localparam int unsigned PERIOD_NS    = 8;
    localparam int unsigned RESET_CYCLES = 5;
    localparam int unsigned WRAP_ISSUES  = 250;

    // Transfers per test: reset, register view, immediate view, branches, errors, wrap
    localparam int unsigned NUM_TRANSFERS = 5 + 44 + 50 + 56 + 14 + (WRAP_ISSUES + 1);
    // Two cycles per transfer plus reset, then doubled for margin
    localparam int unsigned TIMEOUT_NS = (NUM_TRANSFERS * 2 + RESET_CYCLES) * PERIOD_NS * 2;

    localparam alu_cluster_pkg::alu_uop_t REG_OPS [6] = '{
        alu_cluster_pkg::ADD, alu_cluster_pkg::AND, alu_cluster_pkg::OR,
        alu_cluster_pkg::XOR, alu_cluster_pkg::SLT, alu_cluster_pkg::SLTU};
    localparam alu_cluster_pkg::alu_uop_t IMM_OPS [7] = '{
        alu_cluster_pkg::SLL, alu_cluster_pkg::SRL, alu_cluster_pkg::SRA,
        alu_cluster_pkg::SRA, alu_cluster_pkg::ADD, alu_cluster_pkg::ADD, alu_cluster_pkg::XOR};
    // Immediates 7, -3, 33, -1, -2048, 2047, -1366
    localparam logic [11:0] IMM_VALUES [7] = '{
        12'h007, 12'hFFD, 12'h021, 12'hFFF, 12'h800, 12'h7FF, 12'hAAA};
    localparam alu_cluster_pkg::alu_uop_t BRANCH_OPS [6] = '{
        alu_cluster_pkg::BEQ, alu_cluster_pkg::BNE, alu_cluster_pkg::BLT,
        alu_cluster_pkg::BLTU, alu_cluster_pkg::BGE, alu_cluster_pkg::BGEU};
    // Unmapped words and lane 4 of each window, then read-only targets and a missing lane
    localparam logic [7:0] BAD_READS [5]  = '{8'h88, 8'hA0, 8'h10, 8'h50, 8'hD0};
    localparam logic [7:0] BAD_WRITES [4] = '{8'h84, 8'hC0, 8'hCC, 8'h14};

    logic                        clk;
    logic                        rst_n;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    logic [ADDR_W-1:0]           paddr;
    alu_cluster_pkg::data_word_t pwdata;
    alu_cluster_pkg::data_word_t prdata;
    logic                        pready;
    logic                        pslverr;

    // Scoreboard state
    alu_cluster_pkg::data_word_t opa [NUM_LANES];
    alu_cluster_pkg::data_word_t opb [NUM_LANES];
    alu_cluster_pkg::data_word_t exp_res [NUM_LANES];
    logic [NUM_LANES-1:0]        exp_mask;
    int unsigned                 issues;
    int unsigned                 checks;
    int unsigned                 errors;
    logic [31:0]                 lcg_state;

    tb_clock_gen #(
        .PERIOD_NS    (PERIOD_NS),
        .RESET_CYCLES (RESET_CYCLES)
    ) i_tb_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    alu_cluster #(
        .NUM_LANES (NUM_LANES),
        .ADDR_W    (ADDR_W)
    ) i_alu_cluster (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    // ========================================
    // Helpers
    // ========================================

    function automatic alu_cluster_pkg::data_word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Behavioral RV32I lane, signed compare done by flipping the sign bits
    function automatic alu_cluster_pkg::data_word_t alu_model(input logic [3:0] op,
            input logic [31:0] a, input logic [31:0] b, input logic cjump);
        logic [4:0] sh;
        logic       ult;
        logic       slt;
        sh  = b[4:0];
        ult = a < b;
        slt = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
        case (op)
            4'd0:    return cjump ? a + 32'd2 : a + 32'd4;
            4'd1:    return {31'b0, a == b};
            4'd2:    return {31'b0, a != b};
            4'd3:    return {31'b0, slt};
            4'd4:    return {31'b0, ult};
            4'd5:    return {31'b0, !slt};
            4'd6:    return {31'b0, !ult};
            4'd7:    return a + b;
            4'd8:    return a & b;
            4'd9:    return a | b;
            4'd10:   return a ^ b;
            4'd11:   return {31'b0, slt};
            4'd12:   return {31'b0, ult};
            4'd13:   return a << sh;
            4'd14:   return a >> sh;
            default: return a[31] ? ~((~a) >> sh) : (a >> sh);
        endcase
    endfunction

    function automatic alu_cluster_pkg::cmd_word_t make_cmd(input alu_cluster_pkg::alu_uop_t uop,
            input logic imm_sel, input logic cjump, input logic [11:0] imm);
        alu_cluster_pkg::cmd_word_t cmd;
        cmd                  = '0;
        cmd.imm_view.uop     = uop;
        cmd.imm_view.cjump   = cjump;
        cmd.imm_view.imm_sel = imm_sel;
        if (imm_sel) cmd.imm_view.imm = imm;
        return cmd;
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR at %0t: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
        end
    endtask

    // ========================================
    // APB driver
    // ========================================

    // Entered on a falling edge, returns on the falling edge after the access edge
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
            input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        rdata = prdata;
        err   = pslverr;
        check_word("pready_o", 32'd1, 32'(pready));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        apb_transfer(1'b0, addr, 32'd0, data, err);
    endtask

    // ========================================
    // Checking sequences
    // ========================================

    task automatic write_operands();
        logic err;
        for (int l = 0; l < NUM_LANES; l++) begin
            apb_write(8'(alu_cluster_pkg::ADDR_OPA_BASE + 4 * l), opa[l], err);
            check_word("pslverr_o", 32'd0, 32'(err));
            apb_write(8'(alu_cluster_pkg::ADDR_OPB_BASE + 4 * l), opb[l], err);
            check_word("pslverr_o", 32'd0, 32'(err));
        end
    endtask

    // STATUS packs the mask low and the issue count in bits 23..16
    task automatic check_status();
        logic [31:0] act;
        logic        err;
        apb_read(8'(alu_cluster_pkg::ADDR_STATUS), act, err);
        check_word("pslverr_o", 32'd0, 32'(err));
        check_word("status", {8'h00, 8'(issues), 16'(exp_mask)}, act);
    endtask

    task automatic check_results();
        logic [31:0] act;
        logic        err;
        for (int l = 0; l < NUM_LANES; l++) begin
            apb_read(8'(alu_cluster_pkg::ADDR_RES_BASE + 4 * l), act, err);
            check_word("pslverr_o", 32'd0, 32'(err));
            check_word($sformatf("result[%0d]", l), exp_res[l], act);
        end
        check_status();
    endtask

    // Predicts every lane, issues the command, then reads everything back
    task automatic run_and_check(input alu_cluster_pkg::cmd_word_t cmd);
        logic [31:0] b;
        logic        err;
        exp_mask = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            b = cmd.reg_view.imm_sel ? 32'($signed(cmd.imm_view.imm)) : opb[l];
            exp_res[l] = alu_model(cmd.reg_view.uop, opa[l], b, cmd.reg_view.cjump);
            // Codes 0 to 6 are jumps and branches, taken when the result is nonzero
            exp_mask[l] = (cmd.reg_view.uop <= 4'd6) && (exp_res[l] != 32'd0);
        end
        apb_write(8'(alu_cluster_pkg::ADDR_CMD), cmd, err);
        check_word("pslverr_o", 32'd0, 32'(err));
        issues++;
        check_results();
    endtask

    // ========================================
    // Tests
    // ========================================

    task automatic test_reset_values();
        for (int l = 0; l < NUM_LANES; l++) exp_res[l] = '0;
        exp_mask = '0;
        check_results();
    endtask

    task automatic test_register_view();
        for (int l = 0; l < NUM_LANES; l++) begin
            opa[l] = lcg_next();
            opb[l] = lcg_next();
        end
        write_operands();
        for (int i = 0; i < $size(REG_OPS); i++) begin
            run_and_check(make_cmd(REG_OPS[i], 1'b0, 1'b0, 12'h000));
        end
    endtask

    task automatic test_immediate_view();
        for (int l = 0; l < NUM_LANES; l++) begin
            opa[l] = lcg_next();
            opb[l] = lcg_next();
        end
        // Lane 0 negative and lane 1 positive so SRA fills with both signs
        opa[0][31] = 1'b1;
        opa[1][31] = 1'b0;
        write_operands();
        for (int i = 0; i < $size(IMM_OPS); i++) begin
            run_and_check(make_cmd(IMM_OPS[i], 1'b1, 1'b0, IMM_VALUES[i]));
        end
    endtask

    task automatic test_branches();
        // Equal, below on both, below signed only, above on both
        opa = '{32'd5, 32'd3, 32'hFFFF_FFF0, 32'd100};
        opb = '{32'd5, 32'd9, 32'h0000_0010, 32'd7};
        write_operands();
        for (int i = 0; i < $size(BRANCH_OPS); i++) begin
            run_and_check(make_cmd(BRANCH_OPS[i], 1'b0, 1'b0, 12'h000));
        end
        run_and_check(make_cmd(alu_cluster_pkg::JAL, 1'b0, 1'b0, 12'h000));
        run_and_check(make_cmd(alu_cluster_pkg::JAL, 1'b0, 1'b1, 12'h000));
    endtask

    task automatic test_error_responses();
        logic [31:0] act;
        logic        err;
        for (int i = 0; i < $size(BAD_READS); i++) begin
            apb_read(BAD_READS[i], act, err);
            check_word("pslverr_o", 32'd1, 32'(err));
            check_word("prdata_o", 32'd0, act);
        end
        for (int i = 0; i < $size(BAD_WRITES); i++) begin
            apb_write(BAD_WRITES[i], lcg_next(), err);
            check_word("pslverr_o", 32'd1, 32'(err));
        end
        // Rejected writes must leave the last results and status intact
        check_results();
    endtask

    task automatic test_issue_count_wrap();
        logic err;
        for (int i = 0; i < WRAP_ISSUES; i++) begin
            apb_write(8'(alu_cluster_pkg::ADDR_CMD),
                      make_cmd(alu_cluster_pkg::ADD, 1'b0, 1'b0, 12'h000), err);
            check_word("pslverr_o", 32'd0, 32'(err));
            issues++;
        end
        exp_mask = '0;
        check_status();
    endtask

    // ========================================
    // Sequence and watchdog
    // ========================================

    initial begin
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        lcg_state = 32'h1e4d_195a;
        issues    = 0;
        checks    = 0;
        errors    = 0;
        wait (rst_n);
        @(negedge clk);
        test_reset_values();
        test_register_view();
        test_immediate_view();
        test_branches();
        test_error_responses();
        test_issue_count_wrap();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, the test sequence did not finish", TIMEOUT_NS);
        $display("=== FAIL ===");
        $finish;
    end

endmodule : tb_alu_cluster

`default_nettype wire

// ==== vlog.f ====
+incdir+include
source/alu_cluster_pkg.sv
source/arithmetic_logic_unit.sv
source/operand_bank.sv
source/result_collector.sv
source/alu_cluster.sv
testbench/tb_clock_gen.sv
testbench/tb_alu_cluster.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the ALU cluster testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_alu_cluster -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_alu_cluster)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "=== PASS ==="; then
    exit 0
fi
exit 1
